/* common/ann_params.svh */
`ifndef ANN_PARAMS_SVH
`define ANN_PARAMS_SVH

// Lane geometry, Q5.10 lanes in a 128-bit word
`define ANN_LANES      6
`define ANN_DATA_W     16
`define ANN_FRAC_W     10
`define ANN_WORD_W     128

// Fixed-point 1.0 and the activation offset 0.5
`define ANN_ONE        1024
`define ANN_HALF       512

// Memory depths in words
`define ANN_WT_DEPTH   8
`define ANN_IN_DEPTH   4
`define ANN_OUT_DEPTH  8

// Run schedule
`define ANN_IN_ROWS    4
`define ANN_RESULTS    5
`define ANN_ARRAY_LAT  12
`define ANN_DONE_CNT   26

`endif

/* common/ann_pkg.sv */
`default_nettype none

`include "ann_params.svh"

package ann_pkg;

    // Signed Q5.10 lane
    typedef logic signed [`ANN_DATA_W-1:0] lane_t;

    // Memory word, byte view for strobed writes and lane view for the datapath
    typedef union packed {
        logic [`ANN_WORD_W/8-1:0][7:0]          bytes;
        lane_t [`ANN_WORD_W/`ANN_DATA_W-1:0]    lanes;
    } ann_word_u;

endpackage

`default_nettype wire

/* common/ann_ctrl_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ann_params.svh"

interface ann_ctrl_if;

    logic                               wt_rd_en;
    logic [$clog2(`ANN_WT_DEPTH)-1:0]   wt_rd_addr;
    logic                               in_rd_en;
    logic [$clog2(`ANN_IN_DEPTH)-1:0]   in_rd_addr;
    logic                               row_load;
    logic [$clog2(`ANN_IN_DEPTH):0]     row_sel;      // MSB set on the bias step
    logic                               stream_valid;
    logic                               out_wr_en;
    logic [$clog2(`ANN_OUT_DEPTH)-1:0]  out_wr_addr;

    modport sequencer
    (
        output wt_rd_en, wt_rd_addr, in_rd_en, in_rd_addr, row_load, row_sel,
        output stream_valid, out_wr_en, out_wr_addr
    );

    modport datapath
    (
        input wt_rd_en, wt_rd_addr, in_rd_en, in_rd_addr, row_load, row_sel,
        input stream_valid, out_wr_en, out_wr_addr
    );

endinterface

`default_nettype wire

/* systolic/systolic_pe.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ann_params.svh"

module systolic_pe
(
    input wire                  clk,
    input wire                  arst_n,
    input wire ann_pkg::lane_t  a_in,
    input wire ann_pkg::lane_t  x,
    input wire ann_pkg::lane_t  psum_in,
    output ann_pkg::lane_t      a_out,
    output ann_pkg::lane_t      psum_out
);
    import ann_pkg::*;

    logic signed [2*`ANN_DATA_W-1:0] prod;
    lane_t                           prod_q;

    assign prod   = $signed(a_in) * $signed(x);
    assign prod_q = lane_t'(prod >>> `ANN_FRAC_W);  // Back to Q5.10, upper bits dropped

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            a_out    <= '0;
            psum_out <= '0;
        end
        else
        begin
            a_out    <= a_in;
            psum_out <= psum_in + prod_q;  // Wraps at 16 bits
        end
    end

endmodule

`default_nettype wire

/* systolic/systolic_array.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ann_params.svh"

module systolic_array
(
    input wire                      clk,
    input wire                      arst_n,
    ann_ctrl_if.datapath            ctrl,
    input wire ann_pkg::ann_word_u  wt_data,
    input wire ann_pkg::lane_t      x [`ANN_LANES][`ANN_LANES],
    output wire ann_pkg::lane_t     y [`ANN_LANES]
);
    import ann_pkg::*;

    localparam int N = `ANN_LANES;

    wire lane_t a_gate [N];
    wire lane_t a_h [N][N+1];    // Weights moving right, column N leaves the grid
    wire lane_t p_v [N+1][N];    // Partial sums moving down

    for (genvar i = 0; i < N; i++)
    begin : g_skew
        assign a_gate[i] = ctrl.stream_valid ? wt_data.lanes[i] : '0;

        // Row i starts i cycles late
        if (i == 0)
        begin : g_direct
            assign a_h[0][0] = a_gate[0];
        end
        else
        begin : g_dly
            lane_t dly [i];

            always_ff @(posedge clk or negedge arst_n)
            begin
                if (!arst_n)
                    dly <= '{default: '0};
                else
                begin
                    dly[0] <= a_gate[i];
                    for (int d = 1; d < i; d++)
                        dly[d] <= dly[d-1];
                end
            end

            assign a_h[i][0] = dly[i-1];
        end
    end

    for (genvar j = 0; j < N; j++)
    begin : g_top
        assign p_v[0][j] = '0;
    end

    for (genvar i = 0; i < N; i++)
    begin : g_row
        for (genvar j = 0; j < N; j++)
        begin : g_col
            systolic_pe pe0
            (
                .clk(clk), .arst_n(arst_n), .a_in(a_h[i][j]), .x(x[i][j]),
                .psum_in(p_v[i][j]), .a_out(a_h[i][j+1]), .psum_out(p_v[i+1][j])
            );
        end
    end

    // Column j leaves the grid at N+j, pad it out to the full latency
    for (genvar j = 0; j < N; j++)
    begin : g_deskew
        localparam int D = `ANN_ARRAY_LAT - N - j;
        lane_t dly [D];

        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
                dly <= '{default: '0};
            else
            begin
                dly[0] <= p_v[N][j];
                for (int d = 1; d < D; d++)
                    dly[d] <= dly[d-1];
            end
        end

        assign y[j] = dly[D-1];
    end

endmodule

`default_nettype wire

/* source/ann_memory.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ann_params.svh"

module ann_memory
#(
    parameter int DEPTH = 8
)
(
    input wire                          clk,
    input wire                          wr_en,
    input wire [$clog2(DEPTH)-1:0]      wr_addr,
    input wire ann_pkg::ann_word_u      wr_data,
    input wire [`ANN_WORD_W/8-1:0]      wr_strb,
    input wire                          rd_en,
    input wire [$clog2(DEPTH)-1:0]      rd_addr,
    output ann_pkg::ann_word_u          rd_data
);
    import ann_pkg::*;

    ann_word_u mem [DEPTH];

    // Byte-granular write
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int b = 0; b < `ANN_WORD_W/8; b++)
            begin
                if (wr_strb[b])
                    mem[wr_addr].bytes[b] <= wr_data.bytes[b];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];  // Holds last word otherwise
    end

    a_wr_addr_known: assert property (@(posedge clk) wr_en |-> !$isunknown(wr_addr));
    a_rd_addr_known: assert property (@(posedge clk) rd_en |-> !$isunknown(rd_addr));

endmodule

`default_nettype wire

/* source/ann_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ann_params.svh"

module ann_sequencer
(
    input wire              clk,
    input wire              arst_n,
    input wire              start,
    output logic            ready,
    output logic            done,
    ann_ctrl_if.sequencer   ctrl
);
    localparam int CNT_W        = $clog2(`ANN_DONE_CNT + 1);
    localparam int IN_AW        = $clog2(`ANN_IN_DEPTH);
    localparam int WT_AW        = $clog2(`ANN_WT_DEPTH);
    localparam int OUT_AW       = $clog2(`ANN_OUT_DEPTH);
    localparam int IN_RD_FIRST  = 1;
    localparam int ROW_FIRST    = IN_RD_FIRST + 1;                    // After read latency
    localparam int WT_RD_FIRST  = ROW_FIRST + `ANN_IN_ROWS;
    localparam int STREAM_FIRST = WT_RD_FIRST + 1;
    localparam int WR_FIRST     = STREAM_FIRST + `ANN_ARRAY_LAT + 1;  // Array plus activation

    logic [CNT_W-1:0] cnt;
    logic             in_rd_win;
    logic             row_win;
    logic             wt_win;
    logic             stream_win;
    logic             wr_win;

    // Idle at 0, then free-running to the done count
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            cnt <= '0;
        else if (cnt == 0)
        begin
            if (start)
                cnt <= CNT_W'(1);
        end
        else if (cnt == `ANN_DONE_CNT)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    assign in_rd_win  = (cnt >= IN_RD_FIRST) && (cnt < IN_RD_FIRST + `ANN_IN_ROWS);
    assign row_win    = (cnt >= ROW_FIRST) && (cnt < ROW_FIRST + `ANN_IN_ROWS);
    assign wt_win     = (cnt >= WT_RD_FIRST) && (cnt < WT_RD_FIRST + `ANN_RESULTS);
    assign stream_win = (cnt >= STREAM_FIRST) && (cnt < STREAM_FIRST + `ANN_RESULTS);
    assign wr_win     = (cnt >= WR_FIRST) && (cnt < WR_FIRST + `ANN_RESULTS);

    assign ctrl.in_rd_en     = in_rd_win;
    assign ctrl.in_rd_addr   = in_rd_win ? IN_AW'(cnt - IN_RD_FIRST) : '0;
    assign ctrl.row_load     = row_win;
    // Bias rows ride along with row 0
    assign ctrl.row_sel      = row_win ? {cnt == ROW_FIRST, IN_AW'(cnt - ROW_FIRST)} : '0;
    assign ctrl.wt_rd_en     = wt_win;
    assign ctrl.wt_rd_addr   = wt_win ? WT_AW'(cnt - WT_RD_FIRST) : '0;
    assign ctrl.stream_valid = stream_win;
    assign ctrl.out_wr_en    = wr_win;
    assign ctrl.out_wr_addr  = wr_win ? OUT_AW'(cnt - WR_FIRST) : '0;

    assign ready = (cnt == 0);
    assign done  = (cnt == `ANN_DONE_CNT);

    a_ready_done_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(ready && done));

endmodule

`default_nettype wire

/* source/ann_operand_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ann_params.svh"

module ann_operand_bank
(
    input wire                      clk,
    input wire                      arst_n,
    ann_ctrl_if.datapath            ctrl,
    input wire ann_pkg::ann_word_u  in_data,
    output ann_pkg::lane_t          x [`ANN_LANES][`ANN_LANES]
);
    import ann_pkg::*;

    localparam int IN_AW    = $clog2(`ANN_IN_DEPTH);
    localparam int BIAS_ROW = `ANN_IN_ROWS;

    // Rows 0..3 hold input words, row 4 the bias, row 5 is unused and kept at zero
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            x <= '{default: '0};
        else if (ctrl.row_load)
        begin
            for (int j = 0; j < `ANN_LANES; j++)
            begin
                x[ctrl.row_sel[IN_AW-1:0]][j] <= in_data.lanes[j];
            end
            if (ctrl.row_sel[IN_AW])
            begin
                for (int j = 0; j < `ANN_LANES; j++)
                begin
                    x[BIAS_ROW][j]     <= lane_t'(`ANN_ONE);
                    x[BIAS_ROW + 1][j] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/ann_activation.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ann_params.svh"

module ann_activation
(
    input wire              clk,
    input wire              arst_n,
    input wire ann_pkg::lane_t y [`ANN_LANES],
    output ann_pkg::ann_word_u s
);
    import ann_pkg::*;

    // Piecewise-linear sigmoid, y/4 + 0.5 clamped to [0, 1]
    function automatic lane_t hard_sigmoid(input lane_t v);
        lane_t t;
        t = (v >>> 2) + lane_t'(`ANN_HALF);  // No overflow for any 16-bit v
        if (t < 0)
            return '0;
        else if (t > `ANN_ONE)
            return lane_t'(`ANN_ONE);
        else
            return t;
    endfunction

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            s <= '0;
        else
        begin
            s <= '0;  // Upper lanes stay zero
            for (int i = 0; i < `ANN_LANES; i++)
                s.lanes[i] <= hard_sigmoid(y[i]);
        end
    end

    for (genvar i = 0; i < `ANN_LANES; i++)
    begin : g_range
        a_lane_range: assert property (@(posedge clk) disable iff (!arst_n)
            ($signed(s.lanes[i]) >= 0) && ($signed(s.lanes[i]) <= `ANN_ONE));
    end

endmodule

`default_nettype wire

/* source/ann_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ann_params.svh"

module ann_top
(
    input wire                              clk,
    input wire                              arst_n,
    // Weight memory write port
    input wire                              wt_wr_en,
    input wire [2:0]                        wt_wr_addr,
    input wire ann_pkg::ann_word_u          wt_wr_data,
    input wire [15:0]                       wt_wr_strb,
    // Input memory write port
    input wire                              in_wr_en,
    input wire [1:0]                        in_wr_addr,
    input wire ann_pkg::ann_word_u          in_wr_data,
    input wire [15:0]                       in_wr_strb,
    // Output memory read port
    input wire                              out_rd_en,
    input wire [2:0]                        out_rd_addr,
    output ann_pkg::ann_word_u              out_rd_data,
    // Run control
    output logic                            ready,
    input wire                              start,
    output logic                            done
);
    import ann_pkg::*;

    ann_word_u  wt_rd_data;
    ann_word_u  in_rd_data;
    ann_word_u  act_word;
    lane_t      x_bank [`ANN_LANES][`ANN_LANES];
    lane_t      y_array [`ANN_LANES];

    ann_ctrl_if ctrl_if ();

    ann_sequencer seq0 (.clk(clk), .arst_n(arst_n), .start(start), .ready(ready),
                        .done(done), .ctrl(ctrl_if));

    ann_memory #(.DEPTH(`ANN_WT_DEPTH)) wt_mem
    (
        .clk(clk), .wr_en(wt_wr_en), .wr_addr(wt_wr_addr), .wr_data(wt_wr_data),
        .wr_strb(wt_wr_strb), .rd_en(ctrl_if.wt_rd_en), .rd_addr(ctrl_if.wt_rd_addr),
        .rd_data(wt_rd_data)
    );

    ann_memory #(.DEPTH(`ANN_IN_DEPTH)) in_mem
    (
        .clk(clk), .wr_en(in_wr_en), .wr_addr(in_wr_addr), .wr_data(in_wr_data),
        .wr_strb(in_wr_strb), .rd_en(ctrl_if.in_rd_en), .rd_addr(ctrl_if.in_rd_addr),
        .rd_data(in_rd_data)
    );

    ann_operand_bank bank0 (.clk(clk), .arst_n(arst_n), .ctrl(ctrl_if),
                            .in_data(in_rd_data), .x(x_bank));

    systolic_array array0 (.clk(clk), .arst_n(arst_n), .ctrl(ctrl_if),
                           .wt_data(wt_rd_data), .x(x_bank), .y(y_array));

    ann_activation act0 (.clk(clk), .arst_n(arst_n), .y(y_array), .s(act_word));

    // Results are always written as full words
    ann_memory #(.DEPTH(`ANN_OUT_DEPTH)) out_mem
    (
        .clk(clk), .wr_en(ctrl_if.out_wr_en), .wr_addr(ctrl_if.out_wr_addr),
        .wr_data(act_word), .wr_strb({(`ANN_WORD_W/8){1'b1}}), .rd_en(out_rd_en),
        .rd_addr(out_rd_addr), .rd_data(out_rd_data)
    );

endmodule

`default_nettype wire

/* sim/ann_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ann_params.svh"

module ann_tb;
    import ann_pkg::*;

    localparam int RUN_TIMEOUT = 4 * `ANN_DONE_CNT;

    logic        clk;
    logic        arst_n;
    logic        wt_wr_en;
    logic        in_wr_en;
    logic        out_rd_en;
    logic        start;
    logic [2:0]  wt_wr_addr;
    logic [2:0]  out_rd_addr;
    logic [1:0]  in_wr_addr;
    ann_word_u   wt_wr_data;
    ann_word_u   in_wr_data;
    ann_word_u   out_rd_data;
    logic [15:0] wt_wr_strb;
    logic [15:0] in_wr_strb;
    logic        ready;
    logic        done;

    int        seed;
    int        errors;
    int        checks;
    ann_word_u wt_img [`ANN_WT_DEPTH];    // Host view of memory contents
    ann_word_u in_img [`ANN_IN_DEPTH];
    ann_word_u expect_q [`ANN_RESULTS];

    ann_top dut0
    (
        .clk(clk), .arst_n(arst_n),
        .wt_wr_en(wt_wr_en), .wt_wr_addr(wt_wr_addr), .wt_wr_data(wt_wr_data),
        .wt_wr_strb(wt_wr_strb),
        .in_wr_en(in_wr_en), .in_wr_addr(in_wr_addr), .in_wr_data(in_wr_data),
        .in_wr_strb(in_wr_strb),
        .out_rd_en(out_rd_en), .out_rd_addr(out_rd_addr), .out_rd_data(out_rd_data),
        .ready(ready), .start(start), .done(done)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(input string name, input ann_word_u exp, input ann_word_u act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Lanes within +-4.0, upper lanes random too
    function automatic ann_word_u random_word();
        ann_word_u w;
        for (int l = 0; l < `ANN_WORD_W / `ANN_DATA_W; l++)
            w.lanes[l] = lane_t'($random(seed) % 4096);
        return w;
    endfunction

    function automatic lane_t sigmoid_ref(input lane_t v);
        int t;
        t = (int'(v) >>> 2) + `ANN_HALF;
        if (t < 0)
            t = 0;
        if (t > `ANN_ONE)
            t = `ANN_ONE;
        return lane_t'(t);
    endfunction

    // One host write, merged byte by byte into the image as well
    task automatic write_mem(input bit to_wt, input int addr, input ann_word_u data,
                             input logic [15:0] strb);
        @(posedge clk);
        if (to_wt)
        begin
            wt_wr_en   <= 1'b1;
            wt_wr_addr <= 3'(addr);
            wt_wr_data <= data;
            wt_wr_strb <= strb;
        end
        else
        begin
            in_wr_en   <= 1'b1;
            in_wr_addr <= 2'(addr);
            in_wr_data <= data;
            in_wr_strb <= strb;
        end
        for (int b = 0; b < `ANN_WORD_W / 8; b++)
        begin
            if (strb[b] && to_wt)
                wt_img[addr].bytes[b] = data.bytes[b];
            else if (strb[b])
                in_img[addr].bytes[b] = data.bytes[b];
        end
        @(posedge clk);
        wt_wr_en <= 1'b0;
        in_wr_en <= 1'b0;
    endtask

    task automatic load_random();
        for (int a = 0; a < `ANN_RESULTS; a++)
            write_mem(1'b1, a, random_word(), 16'hffff);
        for (int a = 0; a < `ANN_IN_ROWS; a++)
            write_mem(1'b0, a, random_word(), 16'hffff);
    endtask

    // Row 4 is the bias row at 1.0, row 5 is zero
    task automatic compute_model();
        int sum;
        int xv;
        for (int k = 0; k < `ANN_RESULTS; k++)
        begin
            expect_q[k] = '0;
            for (int j = 0; j < `ANN_LANES; j++)
            begin
                sum = 0;
                for (int i = 0; i < `ANN_LANES; i++)
                begin
                    if (i < `ANN_IN_ROWS)
                        xv = in_img[i].lanes[j];
                    else if (i == `ANN_IN_ROWS)
                        xv = `ANN_ONE;
                    else
                        xv = 0;
                    sum += (int'(wt_img[k].lanes[i]) * xv) >>> `ANN_FRAC_W;
                end
                expect_q[k].lanes[j] = sigmoid_ref(lane_t'(sum));  // Wraps at 16 bits
            end
        end
    endtask

    // Start, time done, then read back all results against expect_q
    task automatic run_check(input string name, input bit poke_busy);
        int cyc;
        @(negedge clk);
        check_bit({name, " ready"}, 1'b1, ready);
        @(posedge clk);
        start <= 1'b1;
        cyc = 0;
        while (!done && cyc < RUN_TIMEOUT)
        begin
            @(posedge clk);
            start <= poke_busy && (cyc == 9);   // Lands mid-run
            @(negedge clk);
            cyc++;
        end
        if (!done)
        begin
            errors++;
            $display("%s: done never arrived after start", name);
        end
        else if (cyc != `ANN_DONE_CNT)
        begin
            errors++;
            $display("Error %s: expected done after %0d cycles, actual %0d",
                     name, `ANN_DONE_CNT, cyc);
        end
        @(negedge clk);
        check_bit({name, " done width"}, 1'b0, done);
        check_bit({name, " ready again"}, 1'b1, ready);
        for (int w = 0; w < 2 * `ANN_DONE_CNT; w++)
        begin
            @(negedge clk);
            if (done)
            begin
                errors++;
                $display("%s: a second done followed without a new start", name);
                break;
            end
        end
        for (int k = 0; k < `ANN_RESULTS; k++)
        begin
            @(posedge clk);
            out_rd_en   <= 1'b1;
            out_rd_addr <= 3'(k);
            @(posedge clk);
            out_rd_en <= 1'b0;
            @(negedge clk);
            check_word($sformatf("%s word %0d", name, k), expect_q[k], out_rd_data);
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_bit("reset ready", 1'b1, ready);
        check_bit("reset done", 1'b0, done);
    endtask

    task automatic test_single_run();
        load_random();
        compute_model();
        run_check("single_run", 1'b0);
    endtask

    task automatic test_byte_strobe();
        write_mem(1'b1, 2, random_word(), 16'h3c5a);
        compute_model();
        run_check("byte_strobe", 1'b0);
    endtask

    task automatic test_bias_clamp();
        ann_word_u w;
        for (int a = 0; a < `ANN_IN_ROWS; a++)
            write_mem(1'b0, a, '0, 16'hffff);
        for (int a = 0; a < `ANN_RESULTS; a++)
        begin
            w = random_word();
            w.lanes[`ANN_IN_ROWS] = '0;  // Bias weight off
            write_mem(1'b1, a, w, 16'hffff);
        end
        for (int k = 0; k < `ANN_RESULTS; k++)
        begin
            expect_q[k] = '0;
            for (int j = 0; j < `ANN_LANES; j++)
                expect_q[k].lanes[j] = lane_t'(`ANN_HALF);
        end
        run_check("bias_zero_in", 1'b0);
        // Row 0 at 8.0 and weights of +-2.0 give sums of +-16.0
        w = '0;
        for (int j = 0; j < `ANN_LANES; j++)
            w.lanes[j] = lane_t'(8192);
        write_mem(1'b0, 0, w, 16'hffff);
        for (int a = 0; a < `ANN_RESULTS; a++)
        begin
            w = '0;
            w.lanes[0] = (a % 2) ? lane_t'(2048) : lane_t'(-2048);
            write_mem(1'b1, a, w, 16'hffff);
        end
        compute_model();
        run_check("clamp_large", 1'b0);
    endtask

    task automatic test_busy_start();
        load_random();
        compute_model();
        run_check("busy_start", 1'b1);
    endtask

    task automatic test_back_to_back();
        load_random();
        compute_model();
        run_check("back_to_back_a", 1'b0);
        load_random();
        compute_model();
        run_check("back_to_back_b", 1'b0);
    endtask

    initial
    begin
        seed   = 32'h8fdd;
        errors = 0;
        checks = 0;
        arst_n      <= 1'b0;
        wt_wr_en    <= 1'b0;
        in_wr_en    <= 1'b0;
        out_rd_en   <= 1'b0;
        start       <= 1'b0;
        wt_wr_addr  <= '0;
        in_wr_addr  <= '0;
        out_rd_addr <= '0;
        wt_wr_data  <= '0;
        in_wr_data  <= '0;
        wt_wr_strb  <= '0;
        in_wr_strb  <= '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        test_reset();
        test_single_run();
        test_byte_strobe();
        test_bias_clamp();
        test_busy_start();
        test_back_to_back();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* ann.f */
+incdir+common
common/ann_pkg.sv
common/ann_ctrl_if.sv
systolic/systolic_pe.sv
systolic/systolic_array.sv
source/ann_memory.sv
source/ann_sequencer.sv
source/ann_operand_bank.sv
source/ann_activation.sv
source/ann_top.sv
sim/ann_tb.sv
